// File: source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define INSTR_W      32
`define REG_ADDR_W   5
`define NUM_GPR      32
`define RA_REG       (`NUM_GPR - 1)   // link register

// config word bits
`define CFG_KERNEL_BIT  0
`define CFG_CP0EN_BIT   1

`endif

// File: source/cpu_pkg.sv
`default_nettype none

`include "cpu_config.svh"

package cpu_pkg;

	typedef logic [`INSTR_W-1:0]    uint32_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [1:0]             cfg_t;   // kernel, cp0 enable

	typedef enum logic [6:0] {
		OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
		OP_JALR, OP_MOVN, OP_MOVZ, OP_SYSCALL, OP_BREAK,
		OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
		OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU,
		OP_TGE, OP_TGEU, OP_TLT, OP_TLTU, OP_TEQ, OP_TNE,
		OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU, OP_MUL, OP_CLZ, OP_CLO,
		OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_LUI,
		OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR,
		OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR, OP_CACHE,
		OP_LL, OP_SC,
		OP_JAL,
		OP_MFC0, OP_MTC0,
		OP_TLBR, OP_TLBWI, OP_TLBWR, OP_TLBP,
		OP_ERET,
		OP_INVALID
	} op_t;

	typedef enum logic [1:0] {
		FU_ALU,
		FU_BRANCH,
		FU_CP0,
		FU_INVALID   // also loads and stores
	} fu_t;

	typedef enum logic [2:0] {
		ControlFlow_None,
		ControlFlow_Branch,
		ControlFlow_Jump,
		ControlFlow_Call,
		ControlFlow_Return
	} cf_t;

endpackage

`default_nettype wire

// File: source/decode_branch.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_config.svh"

module decode_branch (
	input  cpu_pkg::uint32_t instr,
	output logic             is_branch,
	output logic             is_jump_i,
	output logic             is_jump_r,
	output logic             is_call,
	output logic             is_return,
	output cpu_pkg::uint32_t imm_branch,
	output logic [25:0]      imm_jump
);

	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rs;
	reg_addr_t  rt;
	logic       regimm_br;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];

	// bltz, bgez, bltzal, bgezal
	assign regimm_br = (opcode == 6'b000001) && (rt[3:1] == 3'b000);

	assign is_branch = (opcode[5:2] == 4'b0001) || regimm_br;
	assign is_jump_i = (opcode[5:1] == 5'b00001);   // j, jal
	assign is_jump_r = (opcode == 6'b000000) && (funct[5:1] == 5'b00100);

	// every linking form counts as a call
	assign is_call   = (opcode == 6'b000011) || (is_jump_r && funct[0]) || (regimm_br && rt[4]);
	assign is_return = is_jump_r && !funct[0] && (rs == reg_addr_t'(`RA_REG));

	assign imm_branch = {{14{instr[15]}}, instr[15:0], 2'b00};
	assign imm_jump   = instr[25:0];

endmodule

`default_nettype wire

// File: source/decoder.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_config.svh"

module decoder (
	input  cpu_pkg::uint32_t   instr,
	output cpu_pkg::reg_addr_t rs1,
	output cpu_pkg::reg_addr_t rs2,
	output cpu_pkg::reg_addr_t rd,
	output cpu_pkg::op_t       op,
	output cpu_pkg::fu_t       fu,
	output cpu_pkg::cf_t       cf,
	output logic               use_imm,
	output logic               imm_signed,
	output logic               is_controlflow,
	output cpu_pkg::uint32_t   branch_offset,
	output logic [25:0]        jump_index
);

	import cpu_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	reg_addr_t  rs_fld;
	reg_addr_t  rt_fld;
	reg_addr_t  rd_fld;
	logic       is_branch;
	logic       is_jump_i;
	logic       is_jump_r;
	logic       is_call;
	logic       is_return;

	assign opcode = instr[31:26];
	assign rs_fld = instr[25:21];
	assign rt_fld = instr[20:16];
	assign rd_fld = instr[15:11];
	assign funct  = instr[5:0];

	decode_branch branch_i (
		.instr      (instr),
		.is_branch  (is_branch),
		.is_jump_i  (is_jump_i),
		.is_jump_r  (is_jump_r),
		.is_call    (is_call),
		.is_return  (is_return),
		.imm_branch (branch_offset),
		.imm_jump   (jump_index)
	);

	assign is_controlflow = is_branch | is_jump_i | is_jump_r;

	always_comb begin
		unique casez ({is_branch, is_return, is_call, is_jump_i | is_jump_r})
			4'b1???: cf = ControlFlow_Branch;
			4'b01??: cf = ControlFlow_Return;
			4'b001?: cf = ControlFlow_Call;
			4'b0001: cf = ControlFlow_Jump;
			default: cf = ControlFlow_None;
		endcase
	end

	always_comb begin
		rs1        = '0;
		rs2        = '0;
		rd         = '0;
		op         = OP_INVALID;
		fu         = FU_INVALID;
		use_imm    = 1'b0;
		imm_signed = 1'b1;

		unique casez (opcode)
			6'b000000: begin   // special
				rs1 = rs_fld;
				rs2 = rt_fld;
				rd  = rd_fld;
				fu  = (funct[5:1] == 5'b00100) ? FU_BRANCH : FU_ALU;
				unique case (funct)
					6'b000000: op = OP_SLL;
					6'b000010: op = OP_SRL;
					6'b000011: op = OP_SRA;
					6'b000100: op = OP_SLLV;
					6'b000110: op = OP_SRLV;
					6'b000111: op = OP_SRAV;
					6'b001000: op = OP_JALR;   // jr
					6'b001001: op = OP_JALR;
					6'b001010: op = OP_MOVZ;
					6'b001011: op = OP_MOVN;
					6'b001100: op = OP_SYSCALL;
					6'b001101: op = OP_BREAK;
					6'b001111: op = OP_SLL;    // sync as nop
					6'b010000: op = OP_MFHI;
					6'b010001: op = OP_MTHI;
					6'b010010: op = OP_MFLO;
					6'b010011: op = OP_MTLO;
					6'b011000: op = OP_MULT;
					6'b011001: op = OP_MULTU;
					6'b011010: op = OP_DIV;
					6'b011011: op = OP_DIVU;
					6'b100000: op = OP_ADD;
					6'b100001: op = OP_ADDU;
					6'b100010: op = OP_SUB;
					6'b100011: op = OP_SUBU;
					6'b100100: op = OP_AND;
					6'b100101: op = OP_OR;
					6'b100110: op = OP_XOR;
					6'b100111: op = OP_NOR;
					6'b101010: op = OP_SLT;
					6'b101011: op = OP_SLTU;
					6'b110000: op = OP_TGE;
					6'b110001: op = OP_TGEU;
					6'b110010: op = OP_TLT;
					6'b110011: op = OP_TLTU;
					6'b110100: op = OP_TEQ;
					6'b110110: op = OP_TNE;
					default:   op = OP_INVALID;
				endcase
			end
			6'b011100: begin   // special2
				rs1 = rs_fld;
				rs2 = rt_fld;
				rd  = rd_fld;
				fu  = FU_ALU;
				unique case (funct)
					6'b000000: op = OP_MADD;
					6'b000001: op = OP_MADDU;
					6'b000010: op = OP_MUL;
					6'b000100: op = OP_MSUB;
					6'b000101: op = OP_MSUBU;
					6'b100000: op = OP_CLZ;
					6'b100001: op = OP_CLO;
					default:   op = OP_INVALID;
				endcase
			end
			6'b000001: begin   // regimm
				rs1     = rs_fld;
				rd      = (instr[20:17] == 4'b1000) ? reg_addr_t'(`RA_REG) : '0;
				use_imm = 1'b1;
				fu      = (instr[19:17] == 3'b000) ? FU_BRANCH : FU_ALU;
				unique case (rt_fld)
					5'b00000: op = OP_BLTZ;
					5'b00001: op = OP_BGEZ;
					5'b10000: op = OP_BLTZAL;
					5'b10001: op = OP_BGEZAL;
					5'b01000: op = OP_TGE;
					5'b01001: op = OP_TGEU;
					5'b01010: op = OP_TLT;
					5'b01011: op = OP_TLTU;
					5'b01100: op = OP_TEQ;
					5'b01110: op = OP_TNE;
					default:  op = OP_INVALID;
				endcase
			end
			6'b0001??: begin   // beq bne blez bgtz
				rs1 = rs_fld;
				rs2 = rt_fld;
				fu  = FU_BRANCH;
				unique case (opcode[1:0])
					2'b00: op = OP_BEQ;
					2'b01: op = OP_BNE;
					2'b10: op = OP_BLEZ;
					2'b11: op = OP_BGTZ;
				endcase
			end
			6'b001???: begin   // alu immediate
				rs1        = rs_fld;
				rd         = rt_fld;
				use_imm    = 1'b1;
				imm_signed = ~opcode[2];   // logical ops zero-extend
				fu         = FU_ALU;
				unique case (opcode[2:0])
					3'b000: op = OP_ADD;
					3'b001: op = OP_ADDU;
					3'b010: op = OP_SLT;
					3'b011: op = OP_SLTU;
					3'b100: op = OP_AND;
					3'b101: op = OP_OR;
					3'b110: op = OP_XOR;
					3'b111: op = OP_LUI;
				endcase
			end
			6'b100???: begin   // loads
				rs1     = rs_fld;
				rs2     = (opcode[1:0] == 2'b10) ? rt_fld : '0;   // lwl/lwr merge
				rd      = rt_fld;
				use_imm = 1'b1;
				unique case (opcode[2:0])
					3'b000: op = OP_LB;
					3'b001: op = OP_LH;
					3'b010: op = OP_LWL;
					3'b011: op = OP_LW;
					3'b100: op = OP_LBU;
					3'b101: op = OP_LHU;
					3'b110: op = OP_LWR;
					3'b111: op = OP_INVALID;
				endcase
			end
			6'b101???: begin   // stores
				rs1     = rs_fld;
				rs2     = rt_fld;
				use_imm = 1'b1;
				unique case (opcode[2:0])
					3'b000:  op = OP_SB;
					3'b001:  op = OP_SH;
					3'b010:  op = OP_SWL;
					3'b011:  op = OP_SW;
					3'b110:  op = OP_SWR;
					3'b111:  op = OP_CACHE;
					default: op = OP_INVALID;
				endcase
			end
			6'b110000: begin   // ll
				rs1     = rs_fld;
				rd      = rt_fld;
				use_imm = 1'b1;
				op      = OP_LL;
			end
			6'b111000: begin   // sc writes success flag to rt
				rs1     = rs_fld;
				rs2     = rt_fld;
				rd      = rt_fld;
				use_imm = 1'b1;
				op      = OP_SC;
			end
			6'b00001?: begin   // j, jal
				rd = opcode[0] ? reg_addr_t'(`RA_REG) : '0;
				fu = FU_BRANCH;
				op = OP_JAL;
			end
			6'b010000: begin   // cop0
				fu = FU_CP0;
				unique casez ({rs_fld, funct})
					11'b00000_??????: begin
						op = OP_MFC0;
						rd = rt_fld;
					end
					11'b00100_??????: begin
						op  = OP_MTC0;
						rs1 = rt_fld;
					end
					11'b10000_000001: op = OP_TLBR;
					11'b10000_000010: op = OP_TLBWI;
					11'b10000_000110: op = OP_TLBWR;
					11'b10000_001000: op = OP_TLBP;
					11'b10000_011000: op = OP_ERET;
					default:          op = OP_INVALID;
				endcase
			end
			default: op = OP_INVALID;
		endcase
	end

endmodule

`default_nettype wire

// File: source/decode_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_config.svh"

module decode_ctrl (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          cfg_we,
	input  cpu_pkg::cfg_t cfg_wdata,
	output cpu_pkg::cfg_t cfg_rdata,
	output logic          cp0_usable
);

	import cpu_pkg::*;

	cfg_t cfg_q;

	// zero after reset means user mode, cop0 off
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg_q <= '0;
		end else if (cfg_we) begin
			cfg_q <= cfg_wdata;
		end
	end

	assign cfg_rdata  = cfg_q;
	assign cp0_usable = cfg_q[`CFG_KERNEL_BIT] | cfg_q[`CFG_CP0EN_BIT];   // kernel implies cop0

endmodule

`default_nettype wire

// File: source/decode_reg.sv
`default_nettype none
`timescale 1ns/1ps

module decode_reg (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  logic               stall,
	input  logic               flush,
	input  cpu_pkg::reg_addr_t rs1,
	input  cpu_pkg::reg_addr_t rs2,
	input  cpu_pkg::reg_addr_t rd,
	input  cpu_pkg::op_t       op,
	input  cpu_pkg::fu_t       fu,
	input  cpu_pkg::cf_t       cf,
	input  logic               use_imm,
	input  logic               imm_signed,
	input  logic               is_controlflow,
	input  cpu_pkg::uint32_t   branch_offset,
	input  logic [25:0]        jump_index,
	input  logic [15:0]        imm_field,
	input  logic               cp0_usable,
	output logic               out_valid,
	output cpu_pkg::reg_addr_t out_rs1,
	output cpu_pkg::reg_addr_t out_rs2,
	output cpu_pkg::reg_addr_t out_rd,
	output cpu_pkg::op_t       out_op,
	output cpu_pkg::fu_t       out_fu,
	output cpu_pkg::cf_t       out_cf,
	output cpu_pkg::uint32_t   out_imm,
	output cpu_pkg::uint32_t   out_branch_offset,
	output logic [25:0]        out_jump_index,
	output logic               out_is_controlflow,
	output logic               exc_ri,
	output logic               exc_cpu
);

	import cpu_pkg::*;

	uint32_t imm;
	logic    ri;
	logic    cpu;

	always_comb begin
		if (!use_imm) begin
			imm = '0;
		end else if (op == OP_LUI) begin
			imm = {imm_field, 16'h0000};
		end else if (imm_signed) begin
			imm = {{16{imm_field[15]}}, imm_field};
		end else begin
			imm = {16'h0000, imm_field};
		end
	end

	assign ri  = (op == OP_INVALID);
	assign cpu = (fu == FU_CP0) && !cp0_usable;

	// flush wins over stall
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			exc_ri    <= 1'b0;
			exc_cpu   <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0;
			exc_ri    <= 1'b0;
			exc_cpu   <= 1'b0;
		end else if (!stall) begin
			out_valid <= in_valid;
			exc_ri    <= in_valid & ri;
			exc_cpu   <= in_valid & cpu;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			out_rs1            <= rs1;
			out_rs2            <= rs2;
			out_rd             <= rd;
			out_op             <= op;
			out_fu             <= fu;
			out_cf             <= cf;
			out_imm            <= imm;
			out_branch_offset  <= branch_offset;
			out_jump_index     <= jump_index;
			out_is_controlflow <= is_controlflow;
		end
	end

endmodule

`default_nettype wire

// File: source/decode_top.sv
`default_nettype none
`timescale 1ns/1ps

module decode_top (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::uint32_t   instr,
	input  logic               in_valid,
	input  logic               stall,
	input  logic               flush,
	input  logic               cfg_we,
	input  cpu_pkg::cfg_t      cfg_wdata,
	output cpu_pkg::cfg_t      cfg_rdata,
	output logic               out_valid,
	output cpu_pkg::reg_addr_t out_rs1,
	output cpu_pkg::reg_addr_t out_rs2,
	output cpu_pkg::reg_addr_t out_rd,
	output cpu_pkg::op_t       out_op,
	output cpu_pkg::fu_t       out_fu,
	output cpu_pkg::cf_t       out_cf,
	output cpu_pkg::uint32_t   out_imm,
	output cpu_pkg::uint32_t   out_branch_offset,
	output logic [25:0]        out_jump_index,
	output logic               out_is_controlflow,
	output logic               exc_ri,
	output logic               exc_cpu
);

	import cpu_pkg::*;

	reg_addr_t   rs1;
	reg_addr_t   rs2;
	reg_addr_t   rd;
	op_t         op;
	fu_t         fu;
	cf_t         cf;
	logic        use_imm;
	logic        imm_signed;
	logic        is_controlflow;
	uint32_t     branch_offset;
	logic [25:0] jump_index;
	logic        cp0_usable;

	decoder decoder_i (.*);

	decode_ctrl ctrl_i (.*);

	decode_reg reg_i (
		.*,
		.imm_field (instr[15:0])   // raw immediate, extended in the register stage
	);

endmodule

`default_nettype wire

// File: sim/decode_top_assertions.sv
`default_nettype none
`timescale 1ns/1ps

module decode_top_assertions (
	input logic               clk,
	input logic               rst_n,
	input logic               stall,
	input logic               flush,
	input logic               out_valid,
	input cpu_pkg::op_t       out_op,
	input cpu_pkg::reg_addr_t out_rd,
	input cpu_pkg::uint32_t   out_imm,
	input logic               exc_ri
);

	import cpu_pkg::*;

	reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
		else $error("out_valid high after reset");

	// register must hold while stalled
	stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
		stall && !flush |=> $stable(out_valid) && $stable(out_op) && $stable(out_rd)
			&& $stable(out_imm))
		else $error("decode outputs changed during stall");

	flush_clears_valid: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> !out_valid)
		else $error("out_valid high one cycle after flush");

	ri_is_invalid_op: assert property (@(posedge clk) disable iff (!rst_n)
		exc_ri |-> out_op == OP_INVALID)
		else $error("exc_ri raised with a valid operation");

endmodule

bind decode_top decode_top_assertions assertions_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.stall     (stall),
	.flush     (flush),
	.out_valid (out_valid),
	.out_op    (out_op),
	.out_rd    (out_rd),
	.out_imm   (out_imm),
	.exc_ri    (exc_ri)
);

`default_nettype wire

// File: sim/decode_top_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_config.svh"

module decode_top_tb;

	import cpu_pkg::*;

	localparam int N_PHASE = 200;
	localparam int N_TMPL  = 24;
	localparam int TIMEOUT = 2 * N_PHASE * 4 + 10 + 40;   // worst case 4 cycles per instr

	localparam reg_addr_t RA = reg_addr_t'(`RA_REG);

	typedef struct packed {
		op_t         op;
		fu_t         fu;
		cf_t         cf;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		reg_addr_t   rd;
		uint32_t     imm;
		uint32_t     boff;
		logic [25:0] jidx;
		logic        ctrl;
		logic        ri;
		logic        cpu;
	} expect_t;

	logic        clk;
	logic        rst_n;
	uint32_t     instr;
	logic        in_valid;
	logic        stall;
	logic        flush;
	logic        cfg_we;
	cfg_t        cfg_wdata;
	cfg_t        cfg_rdata;
	logic        out_valid;
	reg_addr_t   out_rs1;
	reg_addr_t   out_rs2;
	reg_addr_t   out_rd;
	op_t         out_op;
	fu_t         out_fu;
	cf_t         out_cf;
	uint32_t     out_imm;
	uint32_t     out_branch_offset;
	logic [25:0] out_jump_index;
	logic        out_is_controlflow;
	logic        exc_ri;
	logic        exc_cpu;

	expect_t     pending[$];
	logic [15:0] lfsr = 16'd45127;
	cfg_t        cfg_now;
	cfg_t        cfg_model;
	logic        captured = 1'b0;
	int          cycles = 0;
	int          value_errs = 0;
	int          proto_errs = 0;
	int          leftover = 0;

	decode_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic uint32_t take_bits(input int n);
		uint32_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic uint32_t make_instr(input int k, input uint32_t r);
		case (k)
			0:       return {6'h00, r[25:6], 6'h21};   // addu
			1:       return {6'h00, r[25:6], 6'h04};   // sllv
			2:       return {6'h00, r[25:6], 6'h18};   // mult
			3:       return {6'h00, r[25:6], 6'h10};   // mfhi
			4:       return {6'h1c, r[25:6], 6'h02};   // mul
			5:       return {6'h09, r[25:0]};          // addiu
			6:       return {6'h0d, r[25:0]};          // ori
			7:       return {6'h0f, r[25:0]};          // lui
			8:       return {6'h23, r[25:0]};          // lw
			9:       return {6'h24, r[25:0]};          // lbu
			10:      return {6'h2b, r[25:0]};          // sw
			11:      return {6'h04, r[25:0]};          // beq
			12:      return {6'h07, r[25:0]};          // bgtz
			13:      return {6'h01, r[25:21], 5'h11, r[15:0]};   // bgezal
			14:      return {6'h02, r[25:0]};          // j
			15:      return {6'h03, r[25:0]};          // jal
			16:      return {6'h00, r[25:6], 6'h08};   // jr, any rs
			17:      return {6'h00, 5'd31, r[20:6], 6'h08};   // jr ra
			18:      return {6'h00, r[25:6], 6'h09};   // jalr
			19:      return {6'h10, 5'h00, r[20:11], 11'h000};   // mfc0
			20:      return {6'h10, 5'h04, r[20:11], 11'h000};   // mtc0
			21:      return 32'h4200_0018;             // eret
			22:      return {6'h3f, r[25:0]};          // unknown opcode
			default: return {6'h00, r[25:6], 6'h3f};   // unknown special funct
		endcase
	endfunction

	function automatic expect_t expected_decode(input uint32_t w, input cfg_t cfg);
		expect_t    e;
		logic [5:0] opc;
		logic [5:0] fn;
		reg_addr_t  rs;
		reg_addr_t  rt;
		logic       use_imm;
		logic       zext;
		opc     = w[31:26];
		fn      = w[5:0];
		rs      = w[25:21];
		rt      = w[20:16];
		e       = '0;
		e.op    = OP_INVALID;
		e.fu    = FU_INVALID;
		e.cf    = ControlFlow_None;
		e.boff  = {{16{w[15]}}, w[15:0]} << 2;
		e.jidx  = w[25:0];
		use_imm = 1'b0;
		zext    = 1'b0;
		case (opc)
			6'h00: begin
				e.rs1 = rs;
				e.rs2 = rt;
				e.rd  = w[15:11];
				e.fu  = FU_ALU;
				case (fn)
					6'h04: e.op = OP_SLLV;
					6'h10: e.op = OP_MFHI;
					6'h18: e.op = OP_MULT;
					6'h21: e.op = OP_ADDU;
					6'h08, 6'h09: begin
						e.op = OP_JALR;   // jr shares the op
						e.fu = FU_BRANCH;
						if (fn[0])
							e.cf = ControlFlow_Call;
						else if (rs == RA)
							e.cf = ControlFlow_Return;
						else
							e.cf = ControlFlow_Jump;
					end
					default: e.op = OP_INVALID;
				endcase
			end
			6'h1c: begin   // special2
				e.rs1 = rs;
				e.rs2 = rt;
				e.rd  = w[15:11];
				e.fu  = FU_ALU;
				e.op  = (fn == 6'h02) ? OP_MUL : OP_INVALID;
			end
			6'h01: begin
				e.rs1   = rs;
				e.rd    = rt[4] ? RA : '0;
				e.fu    = FU_BRANCH;
				e.cf    = ControlFlow_Branch;
				use_imm = 1'b1;
				e.op    = (rt == 5'h11) ? OP_BGEZAL : OP_INVALID;
			end
			6'h02, 6'h03: begin
				e.op = OP_JAL;
				e.fu = FU_BRANCH;
				e.rd = opc[0] ? RA : '0;
				e.cf = opc[0] ? ControlFlow_Call : ControlFlow_Jump;
			end
			6'h04, 6'h07: begin
				e.rs1 = rs;
				e.rs2 = rt;
				e.fu  = FU_BRANCH;
				e.cf  = ControlFlow_Branch;
				e.op  = (opc == 6'h04) ? OP_BEQ : OP_BGTZ;
			end
			6'h09, 6'h0d, 6'h0f: begin
				e.rs1   = rs;
				e.rd    = rt;
				e.fu    = FU_ALU;
				use_imm = 1'b1;
				zext    = (opc == 6'h0d);
				e.op    = (opc == 6'h09) ? OP_ADDU : (opc == 6'h0d) ? OP_OR : OP_LUI;
			end
			6'h23, 6'h24: begin
				e.rs1   = rs;
				e.rd    = rt;
				use_imm = 1'b1;
				e.op    = (opc == 6'h23) ? OP_LW : OP_LBU;
			end
			6'h2b: begin
				e.rs1   = rs;
				e.rs2   = rt;
				use_imm = 1'b1;
				e.op    = OP_SW;
			end
			6'h10: begin
				e.fu = FU_CP0;
				if (rs == 5'h00) begin
					e.op = OP_MFC0;
					e.rd = rt;
				end else if (rs == 5'h04) begin
					e.op  = OP_MTC0;
					e.rs1 = rt;
				end else if (rs == 5'h10 && fn == 6'h18) begin
					e.op = OP_ERET;
				end
			end
			default: e.op = OP_INVALID;
		endcase
		if (use_imm) begin
			if (e.op == OP_LUI)
				e.imm = {w[15:0], 16'h0000};
			else if (zext)
				e.imm = {16'h0000, w[15:0]};
			else
				e.imm = {{16{w[15]}}, w[15:0]};
		end
		e.ctrl = (e.cf != ControlFlow_None);
		e.ri   = (e.op == OP_INVALID);
		e.cpu  = (e.fu == FU_CP0) && !(cfg[`CFG_KERNEL_BIT] | cfg[`CFG_CP0EN_BIT]);
		return e;
	endfunction

	task automatic check_op(input string name, input op_t got, input op_t want);
		if (got !== want) begin
			value_errs++;
			$display("** Error at %0t: %s is %s, expected %s", $time, name, got.name(), want.name());
		end
	endtask

	task automatic check_fu(input string name, input fu_t got, input fu_t want);
		if (got !== want) begin
			value_errs++;
			$display("** Error at %0t: %s is %s, expected %s", $time, name, got.name(), want.name());
		end
	endtask

	task automatic check_cf(input string name, input cf_t got, input cf_t want);
		if (got !== want) begin
			value_errs++;
			$display("** Error at %0t: %s is %s, expected %s", $time, name, got.name(), want.name());
		end
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t want);
		if (got !== want) begin
			value_errs++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_word(input string name, input uint32_t got, input uint32_t want);
		if (got !== want) begin
			value_errs++;
			$display("** Error at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			value_errs++;
			$display("** Error at %0t: %s is %b, expected %b", $time, name, got, want);
		end
	endtask

	task automatic check_cfg(input string name, input cfg_t got, input cfg_t want);
		if (got !== want) begin
			value_errs++;
			$display("** Error at %0t: %s is %b, expected %b", $time, name, got, want);
		end
	endtask

	// mirror of what the stage accepts on each edge
	always @(posedge clk) begin
		captured <= rst_n && in_valid && !stall && !flush;
		if (!rst_n)
			cfg_model <= '0;
		else if (cfg_we)
			cfg_model <= cfg_wdata;
	end

	always @(negedge clk) begin
		expect_t e;
		check_cfg("cfg_rdata", cfg_rdata, cfg_model);
		if (captured) begin
			if (pending.size() == 0) begin
				proto_errs++;
				$display("instruction accepted at %0t but nothing was expected", $time);
			end else begin
				e = pending.pop_front();
				if (!out_valid) begin
					proto_errs++;
					$display("out_valid stayed low at %0t after an accepted instruction", $time);
				end else begin
					check_op("out_op", out_op, e.op);
					check_fu("out_fu", out_fu, e.fu);
					check_cf("out_cf", out_cf, e.cf);
					check_reg("out_rs1", out_rs1, e.rs1);
					check_reg("out_rs2", out_rs2, e.rs2);
					check_reg("out_rd", out_rd, e.rd);
					check_word("out_imm", out_imm, e.imm);
					check_word("out_branch_offset", out_branch_offset, e.boff);
					check_word("out_jump_index", uint32_t'(out_jump_index), uint32_t'(e.jidx));
					check_flag("out_is_controlflow", out_is_controlflow, e.ctrl);
					check_flag("exc_ri", exc_ri, e.ri);
					check_flag("exc_cpu", exc_cpu, e.cpu);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("run did not finish within %0d cycles", TIMEOUT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	task automatic run_phase(input int n);
		uint32_t w;
		int      n_stall;
		logic    drop;
		for (int i = 0; i < n; i++) begin
			w       = make_instr(int'(take_bits(5) % N_TMPL), take_bits(32));
			n_stall = int'(take_bits(3));
			if (n_stall > 3)
				n_stall = 0;
			drop     = (take_bits(4) == 0);
			instr    <= w;
			in_valid <= 1'b1;
			flush    <= 1'b0;
			repeat (n_stall) begin   // upstream holds instr
				stall <= 1'b1;
				@(posedge clk);
			end
			stall <= 1'b0;
			flush <= drop;
			if (!drop)
				pending.push_back(expected_decode(w, cfg_now));   // flushed entry never queued
			@(posedge clk);
		end
	endtask

	task automatic write_cfg(input cfg_t c);
		in_valid  <= 1'b0;
		stall     <= 1'b0;
		flush     <= 1'b0;
		cfg_we    <= 1'b1;
		cfg_wdata <= c;
		@(posedge clk);
		cfg_we  <= 1'b0;
		cfg_now = c;
	endtask

	initial begin
		cfg_t kernel;
		rst_n     = 1'b0;
		instr     = '0;
		in_valid  = 1'b0;
		stall     = 1'b0;
		flush     = 1'b0;
		cfg_we    = 1'b0;
		cfg_wdata = '0;
		cfg_now   = '0;
		kernel    = '0;
		kernel[`CFG_KERNEL_BIT] = 1'b1;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		run_phase(N_PHASE);   // user mode, cop0 traps
		write_cfg(kernel);
		run_phase(N_PHASE);
		in_valid <= 1'b0;
		flush    <= 1'b0;
		repeat (3) @(posedge clk);
		leftover = pending.size();
		$display("errors: %0d value, %0d protocol, %0d results missing",
			value_errs, proto_errs, leftover);
		if (value_errs == 0 && proto_errs == 0 && leftover == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: decode_top.f
+incdir+source
source/cpu_pkg.sv
source/decode_branch.sv
source/decoder.sv
source/decode_ctrl.sv
source/decode_reg.sv
source/decode_top.sv
sim/decode_top_assertions.sv
sim/decode_top_tb.sv

// File: Makefile
TOP = decode_top_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f decode_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f decode_top.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -qF '*** FAILED ***' sim.log; then exit 1; fi
	@grep -qF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
